// ==== hdl/blob_cfg_pkg.sv ====
`default_nettype none

package blob_cfg_pkg;

    // Frame geometry
    localparam int img_width  = 32;
    localparam int img_height = 24;
    localparam int num_pixels = img_width * img_height;

    localparam int pix_w  = 8;
    localparam int addr_w = $clog2(num_pixels);
    localparam int x_w    = $clog2(img_width);
    localparam int y_w    = $clog2(img_height);

    // Pixels at or above this level are white
    localparam int white_threshold = 180;

    // Inclusive limits for a blob to count as a stripe
    localparam int min_blob_area = 4;
    localparam int max_blob_area = 200;
    localparam int area_w        = 16;

    localparam int stack_depth = 256;
    // Extra bit lets the fill count reach stack_depth
    localparam int stack_ptr_w = $clog2(stack_depth) + 1;

    localparam int min_stripes = 3;
    localparam int max_label   = 179;  // must stay below white_threshold

endpackage

`default_nettype wire

// ==== hdl/blob_ctrl_pkg.sv ====
`default_nettype none

package blob_ctrl_pkg;

    typedef enum logic [3:0] {
        idle,
        scan_read,
        scan_check,
        fill_pop,
        fill_read,
        fill_check,
        push_left,
        push_right,
        push_up,
        push_down,
        blob_end,
        frame_end
    } labeler_state_t;

    typedef enum logic [1:0] {
        op_none,
        op_push,
        op_pop
    } stack_op_t;

endpackage

`default_nettype wire

// ==== hdl/blob_if.sv ====
`default_nettype none

// Address stack requests and status
interface fill_stack_if;
    blob_ctrl_pkg::stack_op_t          op;
    logic [blob_cfg_pkg::addr_w-1:0]   push_addr;
    logic [blob_cfg_pkg::addr_w-1:0]   top_addr;
    logic                              empty;
    logic                              full;

    modport labeler (
        output op, push_addr,
        input  top_addr, empty, full
    );

    modport stack (
        input  op, push_addr,
        output top_addr, empty, full
    );
endinterface

// Per-frame blob reports from labeler to judge
interface blob_report_if;
    logic                              frame_start;
    logic                              blob_valid;
    logic [blob_cfg_pkg::area_w-1:0]   blob_area;
    logic                              frame_end;

    modport labeler (output frame_start, blob_valid, blob_area, frame_end);
    modport judge (input frame_start, blob_valid, blob_area, frame_end);
endinterface

`default_nettype wire

// ==== hdl/frame_ram.sv ====
`default_nettype none

module frame_ram (
    input  wire logic                              clk,

    // Host load and readback port
    input  wire logic                              host_we,
    input  wire logic [blob_cfg_pkg::addr_w-1:0]   host_addr,
    input  wire logic [blob_cfg_pkg::pix_w-1:0]    host_wdata,
    output logic      [blob_cfg_pkg::pix_w-1:0]    host_rdata,

    // Labeler port
    input  wire logic [blob_cfg_pkg::addr_w-1:0]   lab_addr,
    input  wire logic                              lab_we,
    input  wire logic [blob_cfg_pkg::pix_w-1:0]    lab_wdata,
    output logic      [blob_cfg_pkg::pix_w-1:0]    lab_rdata
);

    logic [blob_cfg_pkg::pix_w-1:0] mem [blob_cfg_pkg::num_pixels];

    // Registered reads on both ports, one cycle after the address
    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        // Labeler wins a same-address collision
        if (lab_we) begin
            mem[lab_addr] <= lab_wdata;
        end
        host_rdata <= mem[host_addr];
        lab_rdata  <= mem[lab_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/fill_stack.sv ====
`default_nettype none

module fill_stack (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       clear,
    fill_stack_if.stack     stk,
    output logic            overflow
);

    typedef logic [blob_cfg_pkg::stack_ptr_w-1:0] count_t;
    typedef logic [blob_cfg_pkg::stack_ptr_w-2:0] idx_t;

    localparam count_t full_count = count_t'(blob_cfg_pkg::stack_depth);

    logic [blob_cfg_pkg::addr_w-1:0] entries [blob_cfg_pkg::stack_depth];
    count_t count;
    idx_t   wr_idx;
    idx_t   top_idx;
    logic   do_push;
    logic   do_pop;

    assign wr_idx  = count[blob_cfg_pkg::stack_ptr_w-2:0];
    assign top_idx = wr_idx - 1'b1;

    assign stk.empty    = (count == '0);
    assign stk.full     = (count == full_count);
    assign stk.top_addr = entries[top_idx];

    assign do_push = (stk.op == blob_ctrl_pkg::op_push) && !stk.full;
    assign do_pop  = (stk.op == blob_ctrl_pkg::op_pop) && !stk.empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count    <= '0;
            overflow <= 1'b0;
        end else if (clear) begin
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                count <= count + 1'b1;
            end else if (do_pop) begin
                count <= count - 1'b1;
            end
            // Dropped push is remembered until the next frame
            if (stk.op == blob_ctrl_pkg::op_push && stk.full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_idx] <= stk.push_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/blob_labeler.sv ====
`default_nettype none

module blob_labeler (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              start,
    output logic                                   done,

    // Frame memory
    output logic      [blob_cfg_pkg::addr_w-1:0]   ram_addr,
    output logic                                   ram_we,
    output logic      [blob_cfg_pkg::pix_w-1:0]    ram_wdata,
    input  wire logic [blob_cfg_pkg::pix_w-1:0]    ram_rdata,

    fill_stack_if.labeler                          stk,
    output logic                                   stack_clear,
    blob_report_if.labeler                         rpt
);

    typedef logic [blob_cfg_pkg::addr_w-1:0] addr_t;
    typedef logic [blob_cfg_pkg::pix_w-1:0]  pix_t;
    typedef logic [blob_cfg_pkg::x_w-1:0]    x_t;
    typedef logic [blob_cfg_pkg::y_w-1:0]    y_t;
    typedef logic [blob_cfg_pkg::area_w-1:0] area_t;

    localparam addr_t last_addr = addr_t'(blob_cfg_pkg::num_pixels - 1);
    localparam addr_t row_step  = addr_t'(blob_cfg_pkg::img_width);
    localparam pix_t  white_lvl = pix_t'(blob_cfg_pkg::white_threshold);
    localparam pix_t  last_id   = pix_t'(blob_cfg_pkg::max_label);
    localparam x_t    last_x    = x_t'(blob_cfg_pkg::img_width - 1);
    localparam y_t    last_y    = y_t'(blob_cfg_pkg::img_height - 1);

    blob_ctrl_pkg::labeler_state_t state;
    blob_ctrl_pkg::labeler_state_t after_check;
    blob_ctrl_pkg::labeler_state_t after_left;
    blob_ctrl_pkg::labeler_state_t after_right;
    blob_ctrl_pkg::labeler_state_t after_up;

    addr_t scan_addr;
    addr_t cur_addr;
    area_t area;
    pix_t  label_id;
    x_t    cur_x;
    y_t    cur_y;
    logic  is_white;
    logic  launch;
    logic  has_left;
    logic  has_right;
    logic  has_up;
    logic  has_down;

    assign is_white = (ram_rdata >= white_lvl);
    assign launch   = (state == blob_ctrl_pkg::idle) && start;

    // Position of the pixel being filled
    assign cur_x = x_t'(cur_addr % blob_cfg_pkg::img_width);
    assign cur_y = y_t'(cur_addr / blob_cfg_pkg::img_width);

    assign has_left  = (cur_x != '0);
    assign has_right = (cur_x != last_x);
    assign has_up    = (cur_y != '0);
    assign has_down  = (cur_y != last_y);

    // Skip neighbors that fall outside the frame
    assign after_up    = has_down  ? blob_ctrl_pkg::push_down  : blob_ctrl_pkg::fill_pop;
    assign after_right = has_up    ? blob_ctrl_pkg::push_up    : after_up;
    assign after_left  = has_right ? blob_ctrl_pkg::push_right : after_right;
    assign after_check = has_left  ? blob_ctrl_pkg::push_left  : after_left;

    assign ram_addr  = (state == blob_ctrl_pkg::fill_read || state == blob_ctrl_pkg::fill_check)
                       ? cur_addr : scan_addr;
    assign ram_we    = (state == blob_ctrl_pkg::fill_check) && is_white;
    assign ram_wdata = label_id;

    assign stack_clear     = launch;
    assign rpt.frame_start = launch;
    assign rpt.blob_valid  = (state == blob_ctrl_pkg::blob_end);
    assign rpt.blob_area   = area;
    assign rpt.frame_end   = (state == blob_ctrl_pkg::frame_end);

    always_comb begin
        stk.op        = blob_ctrl_pkg::op_none;
        stk.push_addr = cur_addr;
        case (state)
            blob_ctrl_pkg::scan_check: begin
                // Seed goes on the stack first
                if (is_white) begin
                    stk.op        = blob_ctrl_pkg::op_push;
                    stk.push_addr = scan_addr;
                end
            end
            blob_ctrl_pkg::fill_pop: begin
                if (!stk.empty) begin
                    stk.op = blob_ctrl_pkg::op_pop;
                end
            end
            blob_ctrl_pkg::push_left: begin
                stk.op        = blob_ctrl_pkg::op_push;
                stk.push_addr = cur_addr - 1'b1;
            end
            blob_ctrl_pkg::push_right: begin
                stk.op        = blob_ctrl_pkg::op_push;
                stk.push_addr = cur_addr + 1'b1;
            end
            blob_ctrl_pkg::push_up: begin
                stk.op        = blob_ctrl_pkg::op_push;
                stk.push_addr = cur_addr - row_step;
            end
            blob_ctrl_pkg::push_down: begin
                stk.op        = blob_ctrl_pkg::op_push;
                stk.push_addr = cur_addr + row_step;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= blob_ctrl_pkg::idle;
            scan_addr <= '0;
            cur_addr  <= '0;
            area      <= '0;
            label_id  <= '0;
            done      <= 1'b0;
        end else begin
            // Lines up with the judge publishing its results
            done <= (state == blob_ctrl_pkg::frame_end);
            case (state)
                blob_ctrl_pkg::idle: begin
                    if (start) begin
                        scan_addr <= '0;
                        label_id  <= pix_t'(1);
                        state     <= blob_ctrl_pkg::scan_read;
                    end
                end
                blob_ctrl_pkg::scan_read: begin
                    state <= blob_ctrl_pkg::scan_check;
                end
                blob_ctrl_pkg::scan_check: begin
                    if (is_white) begin
                        area  <= '0;
                        state <= blob_ctrl_pkg::fill_pop;
                    end else if (scan_addr == last_addr) begin
                        state <= blob_ctrl_pkg::frame_end;
                    end else begin
                        scan_addr <= scan_addr + 1'b1;
                        state     <= blob_ctrl_pkg::scan_read;
                    end
                end
                blob_ctrl_pkg::fill_pop: begin
                    if (stk.empty) begin
                        state <= blob_ctrl_pkg::blob_end;
                    end else begin
                        cur_addr <= stk.top_addr;
                        state    <= blob_ctrl_pkg::fill_read;
                    end
                end
                blob_ctrl_pkg::fill_read: begin
                    state <= blob_ctrl_pkg::fill_check;
                end
                blob_ctrl_pkg::fill_check: begin
                    // Already labeled or dark pixels are dropped here
                    if (is_white) begin
                        area  <= area + 1'b1;
                        state <= after_check;
                    end else begin
                        state <= blob_ctrl_pkg::fill_pop;
                    end
                end
                blob_ctrl_pkg::push_left:  state <= after_left;
                blob_ctrl_pkg::push_right: state <= after_right;
                blob_ctrl_pkg::push_up:    state <= after_up;
                blob_ctrl_pkg::push_down:  state <= blob_ctrl_pkg::fill_pop;
                blob_ctrl_pkg::blob_end: begin
                    if (label_id != last_id) begin
                        label_id <= label_id + 1'b1;
                    end
                    if (scan_addr == last_addr) begin
                        state <= blob_ctrl_pkg::frame_end;
                    end else begin
                        scan_addr <= scan_addr + 1'b1;
                        state     <= blob_ctrl_pkg::scan_read;
                    end
                end
                blob_ctrl_pkg::frame_end: begin
                    state <= blob_ctrl_pkg::idle;
                end
                default: begin
                    state <= blob_ctrl_pkg::idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/blob_judge.sv ====
`default_nettype none

module blob_judge (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    blob_report_if.judge                         rpt,
    output logic      [7:0]                      valid_blob_count,
    output logic      [blob_cfg_pkg::area_w-1:0] largest_blob_area,
    output logic                                 zebra_detected
);

    typedef logic [blob_cfg_pkg::area_w-1:0] area_t;

    localparam area_t area_lo = area_t'(blob_cfg_pkg::min_blob_area);
    localparam area_t area_hi = area_t'(blob_cfg_pkg::max_blob_area);

    logic [7:0] run_count;
    area_t      run_max;
    logic       accept;

    assign accept = rpt.blob_valid && (rpt.blob_area >= area_lo) && (rpt.blob_area <= area_hi);

    // Running totals for the frame in progress
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_count <= '0;
            run_max   <= '0;
        end else if (rpt.frame_start) begin
            run_count <= '0;
            run_max   <= '0;
        end else if (accept) begin
            run_count <= run_count + 1'b1;
            if (rpt.blob_area > run_max) begin
                run_max <= rpt.blob_area;
            end
        end
    end

    // Published once per frame, held until the next frame ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_blob_count  <= '0;
            largest_blob_area <= '0;
            zebra_detected    <= 1'b0;
        end else if (rpt.frame_end) begin
            valid_blob_count  <= run_count;
            largest_blob_area <= run_max;
            zebra_detected    <= (run_count >= 8'(blob_cfg_pkg::min_stripes));
        end
    end

endmodule

`default_nettype wire

// ==== hdl/blob_detector_top.sv ====
`default_nettype none

module blob_detector_top (
    input  wire logic                              clk,
    input  wire logic                              rst_n,

    // Host RAM port
    input  wire logic                              load_we,
    input  wire logic [blob_cfg_pkg::addr_w-1:0]   load_addr,
    input  wire logic [blob_cfg_pkg::pix_w-1:0]    load_data,
    output logic      [blob_cfg_pkg::pix_w-1:0]    load_rdata,

    input  wire logic                              start,
    output logic                                   done,

    output logic      [7:0]                        valid_blob_count,
    output logic      [blob_cfg_pkg::area_w-1:0]   largest_blob_area,
    output logic                                   zebra_detected,
    output logic                                   stack_overflow
);

    logic [blob_cfg_pkg::addr_w-1:0] lab_addr;
    logic                            lab_we;
    logic [blob_cfg_pkg::pix_w-1:0]  lab_wdata;
    logic [blob_cfg_pkg::pix_w-1:0]  lab_rdata;
    logic                            stack_clear;

    fill_stack_if  stk_if ();
    blob_report_if rpt_if ();

    frame_ram frame_ram_i (
        .clk        (clk),
        .host_we    (load_we),
        .host_addr  (load_addr),
        .host_wdata (load_data),
        .host_rdata (load_rdata),
        .lab_addr   (lab_addr),
        .lab_we     (lab_we),
        .lab_wdata  (lab_wdata),
        .lab_rdata  (lab_rdata)
    );

    fill_stack fill_stack_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (stack_clear),
        .stk      (stk_if.stack),
        .overflow (stack_overflow)
    );

    blob_labeler blob_labeler_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .done        (done),
        .ram_addr    (lab_addr),
        .ram_we      (lab_we),
        .ram_wdata   (lab_wdata),
        .ram_rdata   (lab_rdata),
        .stk         (stk_if.labeler),
        .stack_clear (stack_clear),
        .rpt         (rpt_if.labeler)
    );

    blob_judge blob_judge_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .rpt               (rpt_if.judge),
        .valid_blob_count  (valid_blob_count),
        .largest_blob_area (largest_blob_area),
        .zebra_detected    (zebra_detected)
    );

endmodule

`default_nettype wire

// ==== tb/blob_detector_tb.sv ====
`default_nettype none

module blob_detector_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [blob_cfg_pkg::addr_w-1:0] addr_t;
    typedef logic [blob_cfg_pkg::pix_w-1:0]  pix_t;

    logic                            clk;
    logic                            rst_n;
    logic                            load_we;
    addr_t                           load_addr;
    pix_t                            load_data;
    pix_t                            load_rdata;
    logic                            start;
    logic                            done;
    logic [7:0]                      valid_blob_count;
    logic [blob_cfg_pkg::area_w-1:0] largest_blob_area;
    logic                            zebra_detected;
    logic                            stack_overflow;

    // Frame as loaded, and the labeled frame the DUT should leave behind
    pix_t img     [blob_cfg_pkg::num_pixels];
    pix_t ref_mem [blob_cfg_pkg::num_pixels];
    int   fill_q  [$];

    int exp_count;
    int exp_largest;
    int exp_zebra;
    int exp_ovf;
    int white_cnt;

    logic [31:0] lcg_state   = 32'h3c61_8fab;
    logic        busy        = 1'b0;
    longint      busy_cycles = 0;
    longint      cycle_limit = 0;

    blob_detector_top blob_detector_top_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .load_we           (load_we),
        .load_addr         (load_addr),
        .load_data         (load_data),
        .load_rdata        (load_rdata),
        .start             (start),
        .done              (done),
        .valid_blob_count  (valid_blob_count),
        .largest_blob_area (largest_blob_area),
        .zebra_detected    (zebra_detected),
        .stack_overflow    (stack_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(string name, int got, int want);
        assert (got == want) else begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, want);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic int rand_below(int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:16]) % n;
    endfunction

    function automatic pix_t white_pixel();
        return pix_t'(blob_cfg_pkg::white_threshold
                      + rand_below(256 - blob_cfg_pkg::white_threshold));
    endfunction

    task automatic clear_frame();
        foreach (img[a]) begin
            img[a] = pix_t'(rand_below(blob_cfg_pkg::white_threshold));
        end
    endtask

    task automatic paint_rect(int x0, int y0, int w, int h);
        for (int y = y0; y < y0 + h; y++) begin
            for (int x = x0; x < x0 + w; x++) begin
                img[y * blob_cfg_pkg::img_width + x] = white_pixel();
            end
        end
    endtask

    // Ragged patches in 8x6 cells that keep a dark gap on their right and bottom
    task automatic random_frame();
        int w;
        int h;
        int ox;
        int oy;
        clear_frame();
        for (int cy = 0; cy < 4; cy++) begin
            for (int cx = 0; cx < 4; cx++) begin
                if (rand_below(4) != 0) begin
                    w  = 1 + rand_below(7);
                    h  = 1 + rand_below(5);
                    ox = cx * 8 + rand_below(8 - w);
                    oy = cy * 6 + rand_below(6 - h);
                    for (int y = oy; y < oy + h; y++) begin
                        for (int x = ox; x < ox + w; x++) begin
                            if (rand_below(4) != 0) begin
                                img[y * blob_cfg_pkg::img_width + x] = white_pixel();
                            end
                        end
                    end
                end
            end
        end
    endtask

    task automatic model_push(int a);
        if (fill_q.size() >= blob_cfg_pkg::stack_depth) begin
            exp_ovf = 1;
        end else begin
            fill_q.push_back(a);
        end
    endtask

    // Reference flood fill over raster seeds with a bounded LIFO and the same push order
    task automatic predict_frame();
        int a;
        int area;
        int id;
        ref_mem     = img;
        exp_count   = 0;
        exp_largest = 0;
        exp_ovf     = 0;
        white_cnt   = 0;
        id          = 1;
        fill_q.delete();
        foreach (img[s]) begin
            if (int'(img[s]) >= blob_cfg_pkg::white_threshold) begin
                white_cnt++;
            end
        end
        for (int s = 0; s < blob_cfg_pkg::num_pixels; s++) begin
            if (int'(ref_mem[s]) >= blob_cfg_pkg::white_threshold) begin
                area = 0;
                model_push(s);
                while (fill_q.size() != 0) begin
                    a = fill_q.pop_back();
                    if (int'(ref_mem[a]) >= blob_cfg_pkg::white_threshold) begin
                        ref_mem[a] = pix_t'(id);
                        area++;
                        if (a % blob_cfg_pkg::img_width != 0) model_push(a - 1);
                        if (a % blob_cfg_pkg::img_width != blob_cfg_pkg::img_width - 1)
                            model_push(a + 1);
                        if (a >= blob_cfg_pkg::img_width) model_push(a - blob_cfg_pkg::img_width);
                        if (a < blob_cfg_pkg::num_pixels - blob_cfg_pkg::img_width)
                            model_push(a + blob_cfg_pkg::img_width);
                    end
                end
                if (area >= blob_cfg_pkg::min_blob_area && area <= blob_cfg_pkg::max_blob_area) begin
                    exp_count++;
                    exp_largest = (area > exp_largest) ? area : exp_largest;
                end
                if (id < blob_cfg_pkg::max_label) id++;
            end
        end
        exp_zebra = (exp_count >= blob_cfg_pkg::min_stripes) ? 1 : 0;
    endtask

    task automatic load_frame();
        foreach (img[a]) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= addr_t'(a);
            load_data <= img[a];
        end
        @(posedge clk);
        load_we <= 0;
    endtask

    // Registered read, so data for an address shows up one edge later
    task automatic check_labels();
        foreach (ref_mem[a]) begin
            @(posedge clk);
            load_addr <= addr_t'(a);
            @(posedge clk);
            @(negedge clk);
            check_value($sformatf("load_rdata at pixel 0x%0h", a),
                        int'(load_rdata), int'(ref_mem[a]));
        end
    endtask

    task automatic run_frame();
        predict_frame();
        cycle_limit += 2 * (2 * blob_cfg_pkg::num_pixels + 7 * (4 * white_cnt + 1));
        @(negedge clk);
        busy = 1'b1;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        do begin
            @(negedge clk);
        end while (!done);
        busy = 1'b0;
        check_value("valid_blob_count", int'(valid_blob_count), exp_count);
        check_value("largest_blob_area", int'(largest_blob_area), exp_largest);
        check_value("zebra_detected", int'(zebra_detected), exp_zebra);
        check_value("stack_overflow", int'(stack_overflow), exp_ovf);
        check_labels();
        img = ref_mem;
    endtask

    always @(posedge clk) begin
        if (busy) begin
            busy_cycles++;
            if (busy_cycles > cycle_limit) begin
                report_failure("Timeout: done did not arrive within the cycle limit");
            end
        end
    end

    // done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else report_failure("done stayed high for more than one cycle");

    // Results only move on the cycle where done rises
    assert property (@(posedge clk) disable iff (!rst_n)
                     !$stable({valid_blob_count, largest_blob_area, zebra_detected})
                     |-> $rose(done))
        else report_failure("Results changed without a done pulse");

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("done", int'(done), 0);
        check_value("zebra_detected", int'(zebra_detected), 0);
        check_value("stack_overflow", int'(stack_overflow), 0);
        check_value("valid_blob_count", int'(valid_blob_count), 0);
        check_value("largest_blob_area", int'(largest_blob_area), 0);

        // Square, a speck and a comb of 216 pixels
        clear_frame();
        paint_rect(2, 2, 5, 5);
        paint_rect(20, 3, 1, 1);
        paint_rect(0, 10, 1, 13);
        for (int r = 10; r <= 22; r += 2) begin
            paint_rect(1, r, 29, 1);
        end
        load_frame();
        run_frame();

        // Three stripes, then a rerun over the labeled frame
        clear_frame();
        for (int k = 0; k < 3; k++) begin
            paint_rect(4 + 6 * k, 2, 2, 20);
        end
        load_frame();
        run_frame();
        run_frame();

        clear_frame();
        paint_rect(6, 2, 2, 20);
        paint_rect(20, 2, 2, 20);
        load_frame();
        run_frame();

        for (int n = 0; n < 4; n++) begin
            random_frame();
            load_frame();
            run_frame();
            check_value("stack_overflow", int'(stack_overflow), 0);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/blob_cfg_pkg.sv
hdl/blob_ctrl_pkg.sv
hdl/blob_if.sv
hdl/frame_ram.sv
hdl/fill_stack.sv
hdl/blob_labeler.sv
hdl/blob_judge.sv
hdl/blob_detector_top.sv
tb/blob_detector_tb.sv

// ==== Makefile ====
TOP       ?= blob_detector_tb
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f tb.f --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf $(OBJ_DIR)
